// ==== hw/csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define CSR_XLEN   32
`define CSR_ADDR_W 12

// machine trap setup and handling
`define CSR_ADDR_MSTATUS       12'h300
`define CSR_ADDR_MISA          12'h301
`define CSR_ADDR_MIE           12'h304
`define CSR_ADDR_MTVEC         12'h305
`define CSR_ADDR_MCOUNTINHIBIT 12'h320
`define CSR_ADDR_MSCRATCH      12'h340
`define CSR_ADDR_MEPC          12'h341
`define CSR_ADDR_MCAUSE        12'h342
`define CSR_ADDR_MTVAL         12'h343

// machine counters
`define CSR_ADDR_MCYCLE        12'hB00
`define CSR_ADDR_MINSTRET      12'hB02

// identity, read-only space
`define CSR_ADDR_MVENDORID     12'hF11
`define CSR_ADDR_MARCHID       12'hF12
`define CSR_ADDR_MIMPID        12'hF13
`define CSR_ADDR_MHARTID       12'hF14

`define CSR_MISA_VALUE 32'h4000_0100 // mxl=1, base I

`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7

`endif

// ==== hw/csr_pkg.sv ====
`include "csr_defines.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0]   csr_data_t;
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef struct packed {
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  typedef struct packed {
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;
    logic      illegal;
  } csr_dec_t;

  typedef struct packed {
    csr_data_t rdata;
    logic      illegal;
  } csr_rsp_t;

  typedef struct packed {
    csr_data_t cause;
    csr_data_t epc;
    csr_data_t tval;
  } trap_info_t;

  // new register value for one access kind
  function automatic csr_data_t csr_apply(csr_op_e op, csr_data_t old_val, csr_data_t wdata);
    case (op)
      CSR_OP_WRITE: csr_apply = wdata;
      CSR_OP_SET:   csr_apply = old_val | wdata;
      CSR_OP_CLEAR: csr_apply = old_val & ~wdata;
      default:      csr_apply = old_val;
    endcase
  endfunction

endpackage

// ==== hw/csr_decode_stage.sv ====
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_decode_stage import csr_pkg::*; (
  input  logic     csr_clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  csr_req_t req_i,
  input  logic     stage_ready_i,
  output csr_dec_t dec_o,
  output logic     commit_o
);

  logic     dec_valid_q;
  csr_dec_t dec_q;
  logic     addr_known;
  logic     addr_ro;
  logic     illegal;
  logic     accept;

  always_comb begin
    case (req_i.addr)
      `CSR_ADDR_MSTATUS,
      `CSR_ADDR_MISA,
      `CSR_ADDR_MIE,
      `CSR_ADDR_MTVEC,
      `CSR_ADDR_MCOUNTINHIBIT,
      `CSR_ADDR_MSCRATCH,
      `CSR_ADDR_MEPC,
      `CSR_ADDR_MCAUSE,
      `CSR_ADDR_MTVAL,
      `CSR_ADDR_MCYCLE,
      `CSR_ADDR_MINSTRET,
      `CSR_ADDR_MVENDORID,
      `CSR_ADDR_MARCHID,
      `CSR_ADDR_MIMPID,
      `CSR_ADDR_MHARTID: addr_known = 1'b1;
      default:           addr_known = 1'b0;
    endcase
  end

  // misa is a constant here, so treat it like the 0xCxx/0xFxx space
  assign addr_ro = (req_i.addr[`CSR_ADDR_W-1 -: 2] == 2'b11) ||
                   (req_i.addr == `CSR_ADDR_MISA);
  assign illegal = !addr_known || (addr_ro && (req_i.op != CSR_OP_READ));

  assign req_ready_o = !dec_valid_q || stage_ready_i; // slot frees as it commits
  assign accept      = req_valid_i && req_ready_o;
  assign commit_o    = dec_valid_q && stage_ready_i;

  always_ff @(posedge csr_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_valid_q <= 1'b0;
    end else if (accept) begin
      dec_valid_q <= 1'b1;
    end else if (commit_o) begin
      dec_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge csr_clk_i) begin
    if (accept) begin
      dec_q.op      <= req_i.op;
      dec_q.addr    <= req_i.addr;
      dec_q.wdata   <= req_i.wdata;
      dec_q.illegal <= illegal;
    end
  end

  assign dec_o = dec_q;

endmodule

// ==== hw/csr_trap_regs.sv ====
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_trap_regs import csr_pkg::*; (
  input  logic       csr_clk_i,
  input  logic       rst_n_i,
  input  csr_dec_t   dec_i,
  input  logic       commit_i,
  input  logic       trap_valid_i,
  input  trap_info_t trap_i,
  input  logic       mret_valid_i,
  output csr_data_t  rdata_o,
  output csr_data_t  mtvec_o,
  output csr_data_t  mepc_o,
  output logic       mstatus_mie_o
);

  logic                   mstatus_mie_q;
  logic                   mstatus_mpie_q;
  csr_data_t              mie_q;
  logic [`CSR_XLEN-1:2]   mtvec_q;     // low bits hardwired to zero
  csr_data_t              mscratch_q;
  logic [`CSR_XLEN-1:2]   mepc_q;
  csr_data_t              mcause_q;
  csr_data_t              mtval_q;
  csr_data_t              mstatus_w;
  csr_data_t              wr_val;
  logic                   wr_en;

  always_comb begin
    mstatus_w                        = '0;
    mstatus_w[`CSR_MSTATUS_MIE_BIT]  = mstatus_mie_q;
    mstatus_w[`CSR_MSTATUS_MPIE_BIT] = mstatus_mpie_q;
  end

  always_comb begin
    case (dec_i.addr)
      `CSR_ADDR_MSTATUS:  rdata_o = mstatus_w;
      `CSR_ADDR_MIE:      rdata_o = mie_q;
      `CSR_ADDR_MTVEC:    rdata_o = {mtvec_q, 2'b00};
      `CSR_ADDR_MSCRATCH: rdata_o = mscratch_q;
      `CSR_ADDR_MEPC:     rdata_o = {mepc_q, 2'b00};
      `CSR_ADDR_MCAUSE:   rdata_o = mcause_q;
      `CSR_ADDR_MTVAL:    rdata_o = mtval_q;
      `CSR_ADDR_MISA:     rdata_o = `CSR_MISA_VALUE;
      `CSR_ADDR_MVENDORID,
      `CSR_ADDR_MARCHID,
      `CSR_ADDR_MIMPID,
      `CSR_ADDR_MHARTID:  rdata_o = '0; // non-commercial, single hart
      default:            rdata_o = '0;
    endcase
  end

  assign wr_en  = commit_i && !dec_i.illegal && (dec_i.op != CSR_OP_READ);
  assign wr_val = csr_apply(dec_i.op, rdata_o, dec_i.wdata);

  always_ff @(posedge csr_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (trap_valid_i) begin
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (mret_valid_i) begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (wr_en && (dec_i.addr == `CSR_ADDR_MSTATUS)) begin
      mstatus_mie_q  <= wr_val[`CSR_MSTATUS_MIE_BIT];
      mstatus_mpie_q <= wr_val[`CSR_MSTATUS_MPIE_BIT];
    end
  end

  // trap record beats a same-cycle csr write
  always_ff @(posedge csr_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (trap_valid_i) begin
      mepc_q   <= trap_i.epc[`CSR_XLEN-1:2];
      mcause_q <= trap_i.cause;
      mtval_q  <= trap_i.tval;
    end else if (wr_en) begin
      if (dec_i.addr == `CSR_ADDR_MEPC)   mepc_q   <= wr_val[`CSR_XLEN-1:2];
      if (dec_i.addr == `CSR_ADDR_MCAUSE) mcause_q <= wr_val;
      if (dec_i.addr == `CSR_ADDR_MTVAL)  mtval_q  <= wr_val;
    end
  end

  always_ff @(posedge csr_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
    end else if (wr_en) begin
      if (dec_i.addr == `CSR_ADDR_MIE)      mie_q      <= wr_val;
      if (dec_i.addr == `CSR_ADDR_MTVEC)    mtvec_q    <= wr_val[`CSR_XLEN-1:2];
      if (dec_i.addr == `CSR_ADDR_MSCRATCH) mscratch_q <= wr_val;
    end
  end

  assign mtvec_o       = {mtvec_q, 2'b00};
  assign mepc_o        = {mepc_q, 2'b00};
  assign mstatus_mie_o = mstatus_mie_q;

endmodule

// ==== hw/csr_counters.sv ====
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_counters import csr_pkg::*; (
  input  logic      csr_clk_i,
  input  logic      rst_n_i,
  input  csr_dec_t  dec_i,
  input  logic      commit_i,
  input  logic      retire_i,
  output csr_data_t rdata_o
);

  csr_data_t mcycle_q;
  csr_data_t minstret_q;
  logic      cy_inhibit_q; // mcountinhibit.CY
  logic      ir_inhibit_q; // mcountinhibit.IR
  csr_data_t inhibit_w;
  csr_data_t wr_val;
  logic      wr_en;

  always_comb begin
    inhibit_w    = '0;
    inhibit_w[0] = cy_inhibit_q;
    inhibit_w[2] = ir_inhibit_q;
  end

  always_comb begin
    case (dec_i.addr)
      `CSR_ADDR_MCYCLE:        rdata_o = mcycle_q;
      `CSR_ADDR_MINSTRET:      rdata_o = minstret_q;
      `CSR_ADDR_MCOUNTINHIBIT: rdata_o = inhibit_w;
      default:                 rdata_o = '0;
    endcase
  end

  assign wr_en  = commit_i && !dec_i.illegal && (dec_i.op != CSR_OP_READ);
  assign wr_val = csr_apply(dec_i.op, rdata_o, dec_i.wdata);

  always_ff @(posedge csr_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mcycle_q     <= '0;
      minstret_q   <= '0;
      cy_inhibit_q <= 1'b0;
      ir_inhibit_q <= 1'b0;
    end else begin
      if (wr_en && (dec_i.addr == `CSR_ADDR_MCYCLE)) begin
        mcycle_q <= wr_val;   // write replaces this cycle's tick
      end else if (!cy_inhibit_q) begin
        mcycle_q <= mcycle_q + csr_data_t'(1);
      end
      if (wr_en && (dec_i.addr == `CSR_ADDR_MINSTRET)) begin
        minstret_q <= wr_val;
      end else if (retire_i && !ir_inhibit_q) begin
        minstret_q <= minstret_q + csr_data_t'(1);
      end
      if (wr_en && (dec_i.addr == `CSR_ADDR_MCOUNTINHIBIT)) begin
        cy_inhibit_q <= wr_val[0];
        ir_inhibit_q <= wr_val[2];
      end
    end
  end

endmodule

// ==== hw/csr_read_stage.sv ====
`timescale 1ns/1ps

module csr_read_stage import csr_pkg::*; (
  input  logic      csr_clk_i,
  input  logic      rst_n_i,
  input  csr_dec_t  dec_i,
  input  logic      commit_i,
  input  csr_data_t trap_rdata_i,
  input  csr_data_t cnt_rdata_i,
  output logic      stage_ready_o,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output csr_rsp_t  rsp_o
);

  logic      rsp_valid_q;
  csr_rsp_t  rsp_q;
  csr_data_t merged_w;

  // blocks drive zero for addresses that are not theirs
  assign merged_w = trap_rdata_i | cnt_rdata_i;

  // slot empty, or emptied by the core this cycle
  assign stage_ready_o = !rsp_valid_q || rsp_ready_i;

  always_ff @(posedge csr_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (commit_i) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge csr_clk_i) begin
    if (commit_i) begin
      rsp_q.rdata   <= dec_i.illegal ? '0 : merged_w;
      rsp_q.illegal <= dec_i.illegal;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== hw/csr_top.sv ====
`timescale 1ns/1ps

module csr_top import csr_pkg::*; (
  input  logic       csr_clk_i,
  input  logic       rst_n_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  csr_req_t   req_i,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output csr_rsp_t   rsp_o,
  input  logic       trap_valid_i,
  input  trap_info_t trap_i,
  input  logic       mret_valid_i,
  input  logic       retire_i,
  output csr_data_t  mtvec_o,
  output csr_data_t  mepc_o,
  output logic       mstatus_mie_o
);

  csr_dec_t  dec_w;
  logic      commit_w;
  logic      stage_ready_w;
  csr_data_t trap_rdata_w;
  csr_data_t cnt_rdata_w;

  csr_decode_stage csr_decode_stage_inst (
    .csr_clk_i     (csr_clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_i         (req_i),
    .stage_ready_i (stage_ready_w),
    .dec_o         (dec_w),
    .commit_o      (commit_w)
  );

  csr_trap_regs csr_trap_regs_inst (
    .csr_clk_i     (csr_clk_i),
    .rst_n_i       (rst_n_i),
    .dec_i         (dec_w),
    .commit_i      (commit_w),
    .trap_valid_i  (trap_valid_i),
    .trap_i        (trap_i),
    .mret_valid_i  (mret_valid_i),
    .rdata_o       (trap_rdata_w),
    .mtvec_o       (mtvec_o),
    .mepc_o        (mepc_o),
    .mstatus_mie_o (mstatus_mie_o)
  );

  csr_counters csr_counters_inst (
    .csr_clk_i (csr_clk_i),
    .rst_n_i   (rst_n_i),
    .dec_i     (dec_w),
    .commit_i  (commit_w),
    .retire_i  (retire_i),
    .rdata_o   (cnt_rdata_w)
  );

  csr_read_stage csr_read_stage_inst (
    .csr_clk_i     (csr_clk_i),
    .rst_n_i       (rst_n_i),
    .dec_i         (dec_w),
    .commit_i      (commit_w),
    .trap_rdata_i  (trap_rdata_w),
    .cnt_rdata_i   (cnt_rdata_w),
    .stage_ready_o (stage_ready_w),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_o         (rsp_o)
  );

endmodule

// ==== test/csr_tb_vectors.svh ====
`ifndef CSR_TB_VECTORS_SVH
`define CSR_TB_VECTORS_SVH

// access rows: op, address, wdata, expected rdata, expected illegal
// other rows: pulse data or cycle count, then expected mtvec_o, mepc_o, mstatus_mie_o
task automatic load_table();
  // mscratch and mtvec read-modify-write
  tbl.push_back(access_row(CSR_OP_WRITE, `CSR_ADDR_MSCRATCH, 32'hA5A50F0F, 32'h0, 1'b0));
  tbl.push_back(access_row(CSR_OP_SET, `CSR_ADDR_MSCRATCH, 32'h0000F000, 32'hA5A50F0F, 1'b0));
  tbl.push_back(access_row(CSR_OP_CLEAR, `CSR_ADDR_MSCRATCH, 32'hA500000F, 32'hA5A5FF0F, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MSCRATCH, 32'h0, 32'h00A5FF00, 1'b0));
  tbl.push_back(access_row(CSR_OP_WRITE, `CSR_ADDR_MTVEC, 32'h80000103, 32'h0, 1'b0));
  tbl.push_back(access_row(CSR_OP_SET, `CSR_ADDR_MTVEC, 32'h00000022, 32'h80000100, 1'b0));
  tbl.push_back(access_row(CSR_OP_CLEAR, `CSR_ADDR_MTVEC, 32'h00000100, 32'h80000120, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MTVEC, 32'h0, 32'h80000020, 1'b0));
  tbl.push_back(idle_row(8'd2, 32'h80000020, 32'h0, 1'b0));
  // illegal accesses
  tbl.push_back(access_row(CSR_OP_READ, 12'h7C0, 32'h0, 32'h0, 1'b1));
  tbl.push_back(access_row(CSR_OP_WRITE, `CSR_ADDR_MISA, 32'hFFFFFFFF, 32'h0, 1'b1));
  tbl.push_back(access_row(CSR_OP_SET, `CSR_ADDR_MVENDORID, 32'h1, 32'h0, 1'b1));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MISA, 32'h0, `CSR_MISA_VALUE, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MHARTID, 32'h0, 32'h0, 1'b0));
  tbl.push_back(access_row(CSR_OP_WRITE, 12'h123, 32'h5, 32'h0, 1'b1));
  // trap entry and mret
  tbl.push_back(access_row(CSR_OP_WRITE, `CSR_ADDR_MSTATUS, 32'h8, 32'h0, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MSTATUS, 32'h0, 32'h8, 1'b0));
  tbl.push_back(idle_row(8'd1, 32'h80000020, 32'h0, 1'b1));
  tbl.push_back(trap_row(32'h2, 32'h1236, 32'hDEADBEEF, 32'h80000020, 32'h1234, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MSTATUS, 32'h0, 32'h80, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MCAUSE, 32'h0, 32'h2, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MTVAL, 32'h0, 32'hDEADBEEF, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MEPC, 32'h0, 32'h1234, 1'b0));
  tbl.push_back(mret_row(32'h80000020, 32'h1234, 1'b1));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MSTATUS, 32'h0, 32'h88, 1'b0));
  // counters, frozen first and then running on retire
  tbl.push_back(access_row(CSR_OP_WRITE, `CSR_ADDR_MCOUNTINHIBIT,
                           32'hFFFFFFFF, 32'h0, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MCOUNTINHIBIT, 32'h0, 32'h5, 1'b0));
  tbl.push_back(blind_access_row(CSR_OP_WRITE, `CSR_ADDR_MCYCLE, 32'h10000000));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MCYCLE, 32'h0, 32'h10000000, 1'b0));
  tbl.push_back(access_row(CSR_OP_WRITE, `CSR_ADDR_MINSTRET, 32'h100, 32'h0, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MINSTRET, 32'h0, 32'h100, 1'b0));
  tbl.push_back(access_row(CSR_OP_CLEAR, `CSR_ADDR_MCOUNTINHIBIT, 32'h5, 32'h5, 1'b0));
  tbl.push_back(retire_row(8'd6));
  tbl.push_back(idle_row(8'd2, 32'h80000020, 32'h1234, 1'b1));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MINSTRET, 32'h0, 32'h106, 1'b0));
  // back-to-back traffic under random back-pressure
  tbl.push_back(access_row(CSR_OP_WRITE, `CSR_ADDR_MSCRATCH, 32'h11111111, 32'h00A5FF00, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MSCRATCH, 32'h0, 32'h11111111, 1'b0));
  tbl.push_back(access_row(CSR_OP_SET, `CSR_ADDR_MSCRATCH, 32'h22220000, 32'h11111111, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MSCRATCH, 32'h0, 32'h33331111, 1'b0));
  tbl.push_back(access_row(CSR_OP_WRITE, `CSR_ADDR_MIE, 32'h888, 32'h0, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MIE, 32'h0, 32'h888, 1'b0));
  tbl.push_back(access_row(CSR_OP_CLEAR, `CSR_ADDR_MSCRATCH, 32'hFFFFFFFF, 32'h33331111, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MSCRATCH, 32'h0, 32'h0, 1'b0));
  tbl.push_back(access_row(CSR_OP_READ, `CSR_ADDR_MISA, 32'h0, `CSR_MISA_VALUE, 1'b0));
  tbl.push_back(idle_row(8'd2, 32'h80000020, 32'h1234, 1'b1));
endtask

`endif

// ==== test/csr_tb.sv ====
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_tb import csr_pkg::*; ();

  typedef enum logic [2:0] {ROW_ACCESS, ROW_TRAP, ROW_MRET, ROW_RETIRE, ROW_IDLE} row_kind_e;

  typedef struct packed {
    row_kind_e  kind;
    csr_req_t   req;
    trap_info_t trap;
    logic [7:0] count;     // retire pulses or idle cycles
    csr_rsp_t   exp_rsp;
    csr_data_t  care;      // rdata bits that are compared
    csr_data_t  exp_mtvec;
    csr_data_t  exp_mepc;
    logic       exp_mie;
  } row_t;

  logic       csr_clk_i;
  logic       rst_n_i;
  logic       req_valid_i;
  logic       req_ready_o;
  csr_req_t   req_i;
  logic       rsp_valid_o;
  logic       rsp_ready_i;
  csr_rsp_t   rsp_o;
  logic       trap_valid_i;
  trap_info_t trap_i;
  logic       mret_valid_i;
  logic       retire_i;
  csr_data_t  mtvec_o;
  csr_data_t  mepc_o;
  logic       mstatus_mie_o;

  row_t        tbl[$];
  csr_rsp_t    exp_q[$];
  csr_data_t   care_q[$];
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  logic [31:0] lfsr_q = 32'h1693;
  logic        held_q = 1'b0; // response stalled at the last falling edge
  csr_rsp_t    held_rsp;

  csr_top csr_top_inst (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
  endfunction

  function automatic row_t access_row(csr_op_e op, csr_addr_t addr, csr_data_t wdata,
                                      csr_data_t rdata, logic ill);
    row_t r;
    r = '0;
    r.kind = ROW_ACCESS;
    r.req.op = op;
    r.req.addr = addr;
    r.req.wdata = wdata;
    r.exp_rsp.rdata = rdata;
    r.exp_rsp.illegal = ill;
    r.care = '1;
    return r;
  endfunction

  // old value not predictable, e.g. a running mcycle
  function automatic row_t blind_access_row(csr_op_e op, csr_addr_t addr, csr_data_t wdata);
    row_t r;
    r = access_row(op, addr, wdata, '0, 1'b0);
    r.care = '0;
    return r;
  endfunction

  function automatic row_t out_row(row_kind_e kind, csr_data_t mtvec, csr_data_t mepc,
                                   logic mie);
    row_t r;
    r = '0;
    r.kind = kind;
    r.exp_mtvec = mtvec;
    r.exp_mepc = mepc;
    r.exp_mie = mie;
    return r;
  endfunction

  function automatic row_t trap_row(csr_data_t cause, csr_data_t epc, csr_data_t tval,
                                    csr_data_t mtvec, csr_data_t mepc, logic mie);
    row_t r;
    r = out_row(ROW_TRAP, mtvec, mepc, mie);
    r.trap.cause = cause;
    r.trap.epc = epc;
    r.trap.tval = tval;
    return r;
  endfunction

  function automatic row_t mret_row(csr_data_t mtvec, csr_data_t mepc, logic mie);
    return out_row(ROW_MRET, mtvec, mepc, mie);
  endfunction

  function automatic row_t retire_row(logic [7:0] n);
    row_t r;
    r = out_row(ROW_RETIRE, '0, '0, 1'b0);
    r.count = n;
    return r;
  endfunction

  function automatic row_t idle_row(logic [7:0] n, csr_data_t mtvec, csr_data_t mepc,
                                    logic mie);
    row_t r;
    r = out_row(ROW_IDLE, mtvec, mepc, mie);
    r.count = n;
    return r;
  endfunction

  `include "csr_tb_vectors.svh"

  task automatic report_fail();
    $display("** FAIL **");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_rsp(input string name, input csr_rsp_t exp, input csr_rsp_t got,
                           input csr_data_t care);
    if ((((exp.rdata ^ got.rdata) & care) !== '0) || (exp.illegal !== got.illegal)) begin
      $display("MISMATCH t=%0t %s expected=%h got=%h", $time, name, exp, got);
      report_fail();
    end
  endtask

  task automatic check_data(input string name, input csr_data_t exp, input csr_data_t got);
    if (exp !== got) begin
      $display("MISMATCH t=%0t %s expected=%h got=%h", $time, name, exp, got);
      report_fail();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (exp !== got) begin
      $display("MISMATCH t=%0t %s expected=%b got=%b", $time, name, exp, got);
      report_fail();
    end
  endtask

  task automatic check_outputs(input row_t r);
    check_data("mtvec_o", r.exp_mtvec, mtvec_o);
    check_data("mepc_o", r.exp_mepc, mepc_o);
    check_bit("mstatus_mie_o", r.exp_mie, mstatus_mie_o);
  endtask

  task automatic next_cycle();
    @(posedge csr_clk_i);
    #1;
  endtask

  task automatic drain_rsp();
    while (exp_q.size() != 0) next_cycle();
  endtask

  task automatic send_access(input row_t r);
    exp_q.push_back(r.exp_rsp);
    care_q.push_back(r.care);
    req_valid_i = 1'b1;
    req_i = r.req;
    @(negedge csr_clk_i);
    while (!req_ready_o) @(negedge csr_clk_i);
    next_cycle(); // accepted on this edge
    req_valid_i = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    case (r.kind)
      ROW_ACCESS: send_access(r);
      ROW_TRAP: begin
        drain_rsp();
        trap_i = r.trap;
        trap_valid_i = 1'b1;
        next_cycle();
        trap_valid_i = 1'b0;
        check_outputs(r);
      end
      ROW_MRET: begin
        drain_rsp();
        mret_valid_i = 1'b1;
        next_cycle();
        mret_valid_i = 1'b0;
        check_outputs(r);
      end
      ROW_RETIRE: begin
        drain_rsp();
        repeat (r.count) begin
          retire_i = 1'b1;
          next_cycle();
        end
        retire_i = 1'b0;
      end
      default: begin
        drain_rsp();
        repeat (r.count) next_cycle();
        check_outputs(r);
      end
    endcase
  endtask

  initial begin
    csr_clk_i = 1'b0;
    forever #4 csr_clk_i = ~csr_clk_i;
  end

  // one lfsr bit per cycle decides whether the core takes a response
  initial begin
    rsp_ready_i = 1'b0;
    forever begin
      next_cycle();
      lfsr_q = lfsr_step(lfsr_q);
      rsp_ready_i = lfsr_q[0];
    end
  end

  always @(posedge csr_clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles with %0d responses never returned",
               cycle_cnt, exp_q.size());
      report_fail();
    end
  end

  // sampled mid-cycle, where outputs and rsp_ready_i are settled
  always @(negedge csr_clk_i) begin
    if (held_q) begin
      check_bit("rsp_valid_o", 1'b1, rsp_valid_o);
      check_rsp("rsp_o", held_rsp, rsp_o, '1);
    end
    held_q = rsp_valid_o && !rsp_ready_i;
    held_rsp = rsp_o;
    if (rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("response taken at t=%0t with no request outstanding", $time);
        report_fail();
      end else begin
        check_rsp("rsp_o", exp_q.pop_front(), rsp_o, care_q.pop_front());
      end
    end
  end

  initial begin
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    trap_valid_i = 1'b0;
    trap_i = '0;
    mret_valid_i = 1'b0;
    retire_i = 1'b0;
    load_table();
    cycle_limit = tbl.size() * 20;
    repeat (2) @(posedge csr_clk_i);
    #1;
    rst_n_i = 1'b1;
    check_bit("req_ready_o", 1'b1, req_ready_o);
    check_bit("rsp_valid_o", 1'b0, rsp_valid_o);
    check_outputs(out_row(ROW_IDLE, '0, '0, 1'b0));
    foreach (tbl[i]) apply_row(tbl[i]);
    drain_rsp();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
+incdir+test
hw/csr_pkg.sv
hw/csr_decode_stage.sv
hw/csr_trap_regs.sv
hw/csr_counters.sv
hw/csr_read_stage.sv
hw/csr_top.sv
test/csr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CSR unit testbench with Verilator, run it and look for the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module csr_tb -o Vcsr_tb

# A failing run stops with a nonzero status. The verdict below comes from the output.
out="$(./obj_dir/Vcsr_tb 2>&1)" || true
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
